// File: Makefile
# builds the logic analyzer testbench with Verilator and runs it

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail if it reports an error"
	@echo "  clean  remove the build directory and the simulation log"

test:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	  --top-module logic_sniffer_tb -Mdir obj_dir -f compile.f
	-./obj_dir/Vlogic_sniffer_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/sample_mem_if.sv
// port of the capture core to the sample memory, the core modport writes and reads it
interface sample_mem_if import sniffer_pkg::*; ();

  logic              we;
  logic [mem_aw-1:0] addr;
  logic [chls_w-1:0] wdata;
  logic [chls_w-1:0] rdata;  // valid one clock after addr

  modport core (
    output we, addr, wdata,
    input  rdata
  );

  modport memory (
    input  we, addr, wdata,
    output rdata
  );

endinterface

// File: common/sniffer_pkg.sv
// shared sizes, SUMP opcodes, UART timing and command word layout, imported by RTL and testbench
package sniffer_pkg;

  localparam int chls_w      = 32;  // input channels, one sample word per clock
  localparam int mem_aw      = 5;
  localparam int word_bits   = 8;   // one UART byte
  localparam int cmd_bytes   = 4;   // data bytes following a long opcode
  localparam int clk_per_bit = 10;
  localparam int baud_cnt_w  = $clog2(clk_per_bit);

  // SUMP opcodes, anything with bit 7 set carries four data bytes
  localparam logic [7:0] opc_reset      = 8'h00;
  localparam logic [7:0] opc_run        = 8'h01;
  localparam logic [7:0] opc_id         = 8'h02;
  localparam logic [7:0] opc_xon        = 8'h11;
  localparam logic [7:0] opc_xoff       = 8'h13;
  localparam logic [7:0] opc_trig_mask  = 8'hC0;
  localparam logic [7:0] opc_trig_value = 8'hC1;
  localparam logic [7:0] opc_counts     = 8'h81;

  // goes out low byte first, so the line shows "1ALS"
  localparam logic [31:0] id_word = 32'h534C_4131;

  localparam logic [2:0] core_idle  = 3'd0;
  localparam logic [2:0] core_armed = 3'd1;  // writing the ring, waiting for a match
  localparam logic [2:0] core_store = 3'd2;  // writing the samples after the match
  localparam logic [2:0] core_read  = 3'd3;  // address presented, read data due next clock
  localparam logic [2:0] core_send  = 3'd4;  // word waiting for the transmitter

  // the four data bytes of a long command, the counts layout is used by opcode 0x81 only
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [15:0] read_count;
      logic [15:0] delay_count;
    } counts;
  } cmd_word_u;

  typedef logic [2:0] tx_sel_t;  // bytes in one transmit request, 1 to 4

endpackage

// File: common/tx_req_if.sv
// transmit request from the core to the UART transmitter, a word of one to four bytes
interface tx_req_if import sniffer_pkg::*; ();

  logic                           stb;   // request is taken when stb and rdy are both high
  logic                           rdy;
  logic [cmd_bytes*word_bits-1:0] data;
  tx_sel_t                        sel;
  logic                           xon;   // one-cycle pulse
  logic                           xoff;  // one-cycle pulse

  // the core raises stb only while rdy is high
  modport core (
    output stb, data, sel, xon, xoff,
    input  rdy
  );

  // rdy drops on the clock after a request and returns after the last stop bit
  modport uart (
    input  stb, data, sel, xon, xoff,
    output rdy
  );

endinterface

// File: compile.f
common/sniffer_pkg.sv
common/sample_mem_if.sv
common/tx_req_if.sv
uart/tuart_rx.sv
uart/tuart_tx.sv
core/sniffer_core.sv
src/sample_ram.sv
src/logic_sniffer.sv
tb/logic_sniffer_tb.sv

// File: core/sniffer_core.sv
// command decoder, trigger compare, ring capture and newest-first readback of the analyzer
module sniffer_core import sniffer_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [chls_w-1:0]    chls_i,
  input  logic [word_bits-1:0] opc_i,
  input  cmd_word_u            cmd_i,
  input  logic                 exec_i,
  sample_mem_if.core           mem,
  tx_req_if.core               tx
);

  logic [2:0]        state;
  logic [chls_w-1:0] trig_mask;
  logic [chls_w-1:0] trig_value;
  logic [15:0]       read_cnt;
  logic [15:0]       delay_cnt;
  logic [15:0]       dly_left;   // samples still to store after the trigger
  logic [15:0]       rd_left;    // words still to send
  logic [mem_aw-1:0] wr_addr;
  logic [mem_aw-1:0] rd_addr;
  logic              id_pend;
  logic              match;
  logic              cap_done;
  logic              take;

  assign match = ((chls_i ^ trig_value) & trig_mask) == '0;

  // the write on this clock is the last one of the capture
  assign cap_done = (state == core_armed && match && delay_cnt == '0) ||
                    (state == core_store && dly_left == 16'd1);

  assign mem.we    = state == core_armed || state == core_store;
  assign mem.addr  = mem.we ? wr_addr : rd_addr;
  assign mem.wdata = chls_i;

  // an id answer goes ahead of a waiting readback word
  assign tx.stb  = tx.rdy && (id_pend || state == core_send);
  assign tx.data = id_pend ? id_word : mem.rdata;
  assign tx.sel  = tx_sel_t'(cmd_bytes);
  assign take    = tx.stb && tx.rdy;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      trig_mask  <= '0;
      trig_value <= '0;
      read_cnt   <= '0;
      delay_cnt  <= '0;
      tx.xon     <= 1'b0;
      tx.xoff    <= 1'b0;
    end else begin
      tx.xon  <= exec_i && opc_i == opc_xon;
      tx.xoff <= exec_i && opc_i == opc_xoff;
      if (exec_i) begin
        case (opc_i)
          opc_trig_mask:  trig_mask <= cmd_i.raw;
          opc_trig_value: trig_value <= cmd_i.raw;
          opc_counts: begin
            read_cnt  <= cmd_i.counts.read_count;
            delay_cnt <= cmd_i.counts.delay_count;
          end
          default: ;  // unknown opcodes are dropped
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state    <= core_idle;
      id_pend  <= 1'b0;
      wr_addr  <= '0;
      rd_addr  <= '0;
      dly_left <= '0;
      rd_left  <= '0;
    end else begin
      if (exec_i && opc_i == opc_id) id_pend <= 1'b1;
      else if (take) id_pend <= 1'b0;

      if (mem.we) wr_addr <= wr_addr + 1'b1;  // the ring simply wraps

      if (exec_i && opc_i == opc_reset) begin
        state <= core_idle;
      end else if (exec_i && opc_i == opc_run) begin
        state <= core_armed;
      end else begin
        case (state)
          core_armed, core_store: begin
            if (cap_done) begin
              rd_addr <= wr_addr;  // newest sample goes out first
              rd_left <= read_cnt;
              state   <= (read_cnt == '0) ? core_idle : core_read;
            end else if (state == core_armed && match) begin
              dly_left <= delay_cnt;
              state    <= core_store;
            end else if (state == core_store) begin
              dly_left <= dly_left - 1'b1;
            end
          end
          core_read: state <= core_send;
          core_send: begin
            if (take && !id_pend) begin
              rd_addr <= rd_addr - 1'b1;
              rd_left <= rd_left - 1'b1;
              state   <= (rd_left == 16'd1) ? core_idle : core_read;
            end
          end
          default: state <= core_idle;
        endcase
      end
    end
  end

  // writing to the ring only ever begins on the clock after a run command
  we_after_run: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem.we) |-> $past(exec_i && opc_i == opc_run));

endmodule

// File: src/logic_sniffer.sv
// top level of the SUMP logic analyzer, connects UART receiver, core, sample memory and transmitter
module logic_sniffer import sniffer_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [chls_w-1:0] chls_i,  // sampled once per clock
  input  logic              rx_i,
  output logic              tx_o
);

  logic [word_bits-1:0] rx_opc;
  cmd_word_u            rx_cmd;
  logic                 rx_exec;

  sample_mem_if mem_bus ();
  tx_req_if     tx_bus ();

  tuart_rx u_rx (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rx_i    (rx_i),
    .opc_o   (rx_opc),
    .cmd_o   (rx_cmd),
    .exec_o  (rx_exec)
  );

  sniffer_core u_core (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .chls_i  (chls_i),
    .opc_i   (rx_opc),
    .cmd_i   (rx_cmd),
    .exec_i  (rx_exec),
    .mem     (mem_bus.core),
    .tx      (tx_bus.core)
  );

  sample_ram u_ram (
    .clk_i (clk_i),
    .mem   (mem_bus.memory)
  );

  tuart_tx u_tx (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .tx      (tx_bus.uart),
    .tx_o    (tx_o)
  );

endmodule

// File: src/sample_ram.sv
// sample ring memory of the capture core, one write port and a registered read on the same address
module sample_ram import sniffer_pkg::*; (
  input  logic         clk_i,
  sample_mem_if.memory mem
);

  logic [chls_w-1:0] ram_q [2**mem_aw];

  always_ff @(posedge clk_i) begin
    if (mem.we) begin
      ram_q[mem.addr] <= mem.wdata;
    end
  end

  // read data shows up one clock after the address
  always_ff @(posedge clk_i) begin
    mem.rdata <= ram_q[mem.addr];
  end

endmodule

// File: tb/logic_sniffer_tb.sv
// testbench of the SUMP logic analyzer, sends commands over rx_i and checks the bytes on tx_o
module logic_sniffer_tb import sniffer_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int max_cmds = 6;
  localparam int n_steps  = 6;
  localparam logic [2:0] chk_id    = 3'd0;  // answer is the id text
  localparam logic [2:0] chk_seq   = 3'd1;  // words fall by one, newest first
  localparam logic [2:0] chk_trig  = 3'd2;
  localparam logic [2:0] chk_flow  = 3'd3;  // xoff and xon in the middle of a readback
  localparam logic [2:0] chk_quiet = 3'd4;

  typedef struct packed {
    logic [2:0]               n_cmds;
    logic [max_cmds-1:0][7:0] opc;
    cmd_word_u [max_cmds-1:0] arg;
    logic [7:0]               n_bytes;  // answer bytes expected on tx_o
    logic [2:0]               kind;
  } step_t;

  logic              clk_i;
  logic              rst_n_i;
  logic [chls_w-1:0] chls_i;
  logic              rx_i;
  logic              tx_o;

  step_t       steps [n_steps];
  logic [7:0]  rx_bytes [$];
  logic [7:0]  id_bytes [4] = '{8'h31, 8'h41, 8'h4C, 8'h53};  // "1ALS"
  int unsigned starts_seen = 0;
  int unsigned cycles = 0;
  int unsigned limit = 0;
  int          trig_rd;
  int          trig_dly;

  logic_sniffer logic_sniffer_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .chls_i  (chls_i),
    .rx_i    (rx_i),
    .tx_o    (tx_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // the channels see a counter, so every stored sample is one more than the one before
  initial begin : chls_counter
    logic running;
    chls_i = '0;
    forever begin
      @(posedge clk_i);
      running = rst_n_i;
      #10;
      if (running) chls_i = chls_i + 1'b1;
    end
  end

  // decodes tx_o at mid-bit on the falling clock edge, where it is stable
  initial begin : tx_monitor
    logic [7:0] b;
    forever begin
      @(negedge tx_o);
      starts_seen++;
      repeat (clk_per_bit / 2) @(negedge clk_i);
      for (int i = 0; i < 8; i++) begin
        repeat (clk_per_bit) @(negedge clk_i);
        b[i] = tx_o;
      end
      repeat (clk_per_bit) @(negedge clk_i);
      check_value("tx_o stop bit", 32'(tx_o), 32'd1);
      rx_bytes.push_back(b);
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout after %0d cycles while waiting for the DUT to answer", cycles);
      $display("tests failed");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};  // start bit goes out first
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_i);
      #10;
      rx_i = frame[i];
      repeat (clk_per_bit - 1) @(posedge clk_i);
    end
  endtask

  task automatic send_command(input logic [7:0] opc, input cmd_word_u arg);
    send_byte(opc);
    if (opc[7]) begin
      for (int i = 0; i < cmd_bytes; i++) send_byte(arg.raw[8*i +: 8]);  // low byte first
    end
  endtask

  function automatic cmd_word_u raw_word(input logic [31:0] v);
    cmd_word_u w;
    w.raw = v;
    return w;
  endfunction

  function automatic cmd_word_u counts_word(input int rd, input int dly);
    cmd_word_u w;
    w.counts.read_count  = 16'(rd);
    w.counts.delay_count = 16'(dly);
    return w;
  endfunction

  task automatic add_command(input int row, input logic [7:0] opc, input cmd_word_u arg);
    steps[row].opc[steps[row].n_cmds] = opc;
    steps[row].arg[steps[row].n_cmds] = arg;
    steps[row].n_cmds = steps[row].n_cmds + 3'd1;
  endtask

  task automatic set_answer(input int row, input int n_bytes, input logic [2:0] kind);
    steps[row].n_bytes = 8'(n_bytes);
    steps[row].kind    = kind;
  endtask

  task automatic fill_table();
    for (int r = 0; r < n_steps; r++) steps[r] = '0;
    add_command(0, opc_id, raw_word('0));
    set_answer(0, 4, chk_id);
    add_command(1, opc_trig_mask, raw_word('0));
    add_command(1, opc_counts, counts_word(4, 8));
    add_command(1, opc_run, raw_word('0));
    set_answer(1, 16, chk_seq);
    add_command(2, opc_trig_mask, raw_word(32'h0000_00FF));
    add_command(2, opc_trig_value, raw_word(32'h0000_0040));
    add_command(2, opc_counts, counts_word(trig_rd, trig_dly));
    add_command(2, opc_run, raw_word('0));
    set_answer(2, 4 * trig_rd, chk_trig);
    add_command(3, opc_trig_mask, raw_word('0));
    add_command(3, opc_counts, counts_word(8, 8));
    add_command(3, opc_run, raw_word('0));
    set_answer(3, 32, chk_flow);
    // the counter never sets bit 31 within the run, so this capture cannot trigger
    add_command(4, opc_trig_mask, raw_word(32'h8000_0000));
    add_command(4, opc_trig_value, raw_word(32'h8000_0000));
    add_command(4, opc_run, raw_word('0));
    add_command(4, opc_reset, raw_word('0));
    add_command(4, 8'h55, raw_word('0));
    add_command(4, opc_trig_mask, raw_word('0));  // a capture still armed would fire now
    set_answer(4, 0, chk_quiet);
    add_command(5, opc_id, raw_word('0));
    set_answer(5, 4, chk_id);
  endtask

  function automatic logic [31:0] answer_word(input int k);
    return {rx_bytes[4*k+3], rx_bytes[4*k+2], rx_bytes[4*k+1], rx_bytes[4*k]};
  endfunction

  task automatic check_descending();
    for (int k = 1; k < rx_bytes.size() / 4; k++) begin
      check_value("readback word", answer_word(k), answer_word(k - 1) - 32'd1);
    end
  endtask

  task automatic pause_and_resume();
    int unsigned seen;
    while (rx_bytes.size() < 4) @(posedge clk_i);
    send_byte(opc_xoff);
    repeat (20) @(posedge clk_i);
    seen = starts_seen;  // the byte in flight has already started
    repeat (50 * clk_per_bit) @(posedge clk_i);
    check_value("tx_o start bits while paused", 32'(starts_seen), 32'(seen));
    send_byte(opc_xon);
  endtask

  initial begin : run_tests
    int unsigned sent;
    logic [31:0] w;
    rst_n_i = 1'b0;
    rx_i    = 1'b1;
    void'($urandom(32'hd437_3e50));
    trig_dly = 1 + int'($urandom % 31);
    trig_rd  = 1 + int'($urandom % 32'(trig_dly));
    fill_table();
    sent = 0;
    for (int r = 0; r < n_steps; r++) begin
      for (int c = 0; c < int'(steps[r].n_cmds); c++) sent += steps[r].opc[c][7] ? 5 : 1;
      sent += steps[r].n_bytes + ((steps[r].kind == chk_flow) ? 2 : 0);
    end
    limit = sent * 10 * clk_per_bit * 2 + 2000;
    repeat (16) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    check_value("tx_o after reset", 32'(tx_o), 32'd1);
    for (int r = 0; r < n_steps; r++) begin
      rx_bytes.delete();
      for (int c = 0; c < int'(steps[r].n_cmds); c++) begin
        send_command(steps[r].opc[c], steps[r].arg[c]);
      end
      if (steps[r].kind == chk_flow) pause_and_resume();
      while (rx_bytes.size() < int'(steps[r].n_bytes)) @(posedge clk_i);
      repeat (30 * clk_per_bit) @(posedge clk_i);  // room for any extra byte to show up
      check_value("answer byte count", 32'(rx_bytes.size()), 32'(steps[r].n_bytes));
      case (steps[r].kind)
        chk_id: begin
          for (int k = 0; k < 4; k++) begin
            check_value("id byte", 32'(rx_bytes[k]), 32'(id_bytes[k]));
          end
        end
        chk_seq, chk_flow: check_descending();
        chk_trig: begin
          check_descending();
          w = answer_word(0);
          check_value("trigger word low byte", 32'(w[7:0]), 32'(8'(8'h40 + trig_dly)));
        end
        default: ;
      endcase
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// File: uart/tuart_rx.sv
// UART receiver that collects an opcode plus four data bytes for long commands, then strobes exec
module tuart_rx import sniffer_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 rx_i,
  output logic [word_bits-1:0] opc_o,
  output cmd_word_u            cmd_o,
  output logic                 exec_o
);

  logic [1:0]                     rx_sync;
  logic                           busy;
  logic [3:0]                     bit_idx;  // 0 is the start bit, word_bits + 1 the stop bit
  logic [baud_cnt_w-1:0]          clk_cnt;
  logic [word_bits-1:0]           shift_q;
  logic                           byte_vld;
  logic                           collecting;
  logic [$clog2(cmd_bytes)-1:0]   byte_cnt;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_sync  <= 2'b11;  // idle line is high
      busy     <= 1'b0;
      bit_idx  <= '0;
      clk_cnt  <= '0;
      byte_vld <= 1'b0;
    end else begin
      rx_sync  <= {rx_sync[0], rx_i};
      byte_vld <= 1'b0;
      if (!busy) begin
        if (!rx_sync[1]) begin  // falling edge of a start bit
          busy    <= 1'b1;
          bit_idx <= '0;
          clk_cnt <= '0;
        end
      end else if ((bit_idx == '0 && clk_cnt == baud_cnt_w'(clk_per_bit / 2 - 1)) ||
                   (bit_idx != '0 && clk_cnt == baud_cnt_w'(clk_per_bit - 1))) begin
        clk_cnt <= '0;
        if (bit_idx == '0) begin
          if (rx_sync[1]) busy <= 1'b0;  // a glitch, no real start bit
          else bit_idx <= 4'd1;
        end else if (bit_idx == 4'(word_bits + 1)) begin
          busy     <= 1'b0;
          byte_vld <= rx_sync[1];  // a missing stop bit drops the byte
        end else begin
          bit_idx <= bit_idx + 1'b1;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // the shift register picks up each data bit at mid-period, least significant bit first
  always_ff @(posedge clk_i) begin
    if (busy && bit_idx != '0 && bit_idx != 4'(word_bits + 1) &&
        clk_cnt == baud_cnt_w'(clk_per_bit - 1)) begin
      shift_q <= {rx_sync[1], shift_q[word_bits-1:1]};
    end
    if (byte_vld && !collecting) opc_o <= shift_q;
    if (byte_vld && collecting) cmd_o.raw <= {shift_q, cmd_o.raw[31:word_bits]};
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      collecting <= 1'b0;
      byte_cnt   <= '0;
      exec_o     <= 1'b0;
    end else begin
      exec_o <= 1'b0;
      if (byte_vld) begin
        if (!collecting) begin
          if (shift_q[word_bits-1]) begin  // long command, data bytes follow
            collecting <= 1'b1;
            byte_cnt   <= '0;
          end else begin
            exec_o <= 1'b1;
          end
        end else begin
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == 2'(cmd_bytes - 1)) begin
            collecting <= 1'b0;
            exec_o     <= 1'b1;
          end
        end
      end
    end
  end

  // commands are at least one byte apart, so exec is always a single pulse
  exec_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exec_o |=> !exec_o);

endmodule

// File: uart/tuart_tx.sv
// UART transmitter that sends one to four bytes of a request word, low byte first, with xon/xoff
module tuart_tx import sniffer_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  tx_req_if.uart tx,
  output logic   tx_o
);

  logic [cmd_bytes*word_bits-1:0] data_q;
  logic [word_bits:0]             shift_q;  // stop bit sits above the data byte
  tx_sel_t                        left;     // bytes not yet started
  logic                           sending;
  logic                           paused;
  logic [3:0]                     bit_idx;
  logic [baud_cnt_w-1:0]          clk_cnt;
  logic                           take;
  logic                           start_byte;
  logic                           bit_end;

  assign take       = tx.stb && tx.rdy;
  assign start_byte = !sending && left != '0 && !paused;  // xoff only holds back the next byte
  assign bit_end    = sending && clk_cnt == baud_cnt_w'(clk_per_bit - 1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx.rdy  <= 1'b1;
      left    <= '0;
      sending <= 1'b0;
      paused  <= 1'b0;
      bit_idx <= '0;
      clk_cnt <= '0;
      tx_o    <= 1'b1;
    end else begin
      if (tx.xoff) paused <= 1'b1;
      else if (tx.xon) paused <= 1'b0;

      if (take) begin
        tx.rdy <= 1'b0;
        left   <= tx.sel;
      end else if (start_byte) begin
        sending <= 1'b1;
        left    <= left - 1'b1;
        bit_idx <= '0;
        clk_cnt <= '0;
        tx_o    <= 1'b0;  // start bit
      end else if (bit_end) begin
        clk_cnt <= '0;
        if (bit_idx == 4'(word_bits + 1)) begin
          sending <= 1'b0;
          if (left == '0) tx.rdy <= 1'b1;  // stop bit of the last byte is done
        end else begin
          bit_idx <= bit_idx + 1'b1;
          tx_o    <= shift_q[0];
        end
      end else if (sending) begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) data_q <= tx.data;
    else if (start_byte) data_q <= data_q >> word_bits;

    if (start_byte) shift_q <= {1'b1, data_q[word_bits-1:0]};
    else if (bit_end) shift_q <= {1'b1, shift_q[word_bits:1]};
  end

  // the core must ask for at least one byte and no more than a word holds
  sel_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    take |-> (tx.sel >= 3'd1 && tx.sel <= tx_sel_t'(cmd_bytes)));

endmodule
